// File: rtl/daq_pkg.sv
package daq_pkg;

  // --------------------
  // bus register map
  // --------------------
  localparam logic [18:0] addr_status      = 19'd0;
  localparam logic [18:0] addr_cmd_w1      = 19'd1;
  localparam logic [18:0] addr_cmd_w2      = 19'd2;
  localparam logic [18:0] addr_cmd_w3      = 19'd3;
  localparam logic [18:0] addr_cmd_w4      = 19'd4;
  localparam logic [18:0] addr_cmd_w5      = 19'd5;
  localparam logic [18:0] addr_next_sample = 19'd6;
  localparam logic [18:0] addr_reset_time  = 19'd7;
  localparam logic [18:0] addr_run_time    = 19'd8;

  // --------------------
  // command layout
  // --------------------
  localparam int cmd_w = 80;

  // word 1 sits in the top bits with the opcode in its upper nibble
  localparam int cmd_word1_lsb = 64;
  localparam int cmd_op_lsb    = 76;
  localparam int cmd_count_lsb = 48;
  localparam int cmd_start_lsb = 32;
  localparam int cmd_step_lsb  = 16;
  localparam int cmd_tag_lsb   = 0;

  typedef enum logic [3:0] {
    op_nop  = 4'h0,
    op_ramp = 4'h1,
    op_fill = 4'h2
  } opcode_t;

  typedef enum logic [2:0] {
    st_fetch,
    st_cmd_push,
    st_wait_release,
    st_read_hold,
    st_read_done
  } bridge_state_t;

  // fifo depths
  localparam int cmd_depth    = 4;
  localparam int sample_depth = 16;

  // --------------------
  // status word
  // --------------------
  localparam int stat_cmd_afull       = 15;
  localparam int stat_cmd_full        = 14;
  localparam int stat_cmd_aempty      = 13;
  localparam int stat_cmd_empty       = 12;
  localparam int stat_smp_afull       = 11;
  localparam int stat_smp_full        = 10;
  localparam int stat_smp_empty       = 9;
  localparam int stat_smp_aempty      = 8;
  localparam int stat_sample_valid    = 0;

  // both fifos empty and nothing prefetched
  localparam logic [15:0] status_reset = 16'h1200;

  localparam logic [15:0] empty_sample = 16'hdead;

endpackage

// File: rtl/sync_fifo.sv
module sync_fifo #(
  parameter int WIDTH = 16,
  parameter int DEPTH = 16
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] wr_data,
  input  logic             rd_en,
  output logic [WIDTH-1:0] rd_data,
  output logic             full,
  output logic             almost_full,
  output logic             empty,
  output logic             almost_empty
);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic do_wr;
  logic do_rd;

  // overflow and underflow attempts are simply ignored
  assign do_wr = wr_en & ~full;
  assign do_rd = rd_en & ~empty;

  assign full         = (count == $bits(count)'(DEPTH));
  assign almost_full  = (count == $bits(count)'(DEPTH - 1));
  assign empty        = (count == '0);
  assign almost_empty = (count == $bits(count)'(1));

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == $bits(wr_ptr)'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == $bits(rd_ptr)'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  // storage and read data
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
    if (do_rd) begin
      rd_data <= mem[rd_ptr];
    end
  end

endmodule

// File: rtl/ebi_bridge.sv
module ebi_bridge (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      cs,
  input  logic                      rd,
  input  logic                      wr,
  input  logic [18:0]               addr,
  input  logic [15:0]               data_in,
  output logic [15:0]               data_out,
  output logic                      irq,
  output logic [31:0]               global_clock,
  output logic                      cmd_wr_en,
  output logic [daq_pkg::cmd_w-1:0] cmd_data,
  input  logic                      cmd_full,
  input  logic                      cmd_almost_full,
  input  logic                      cmd_empty,
  input  logic                      cmd_almost_empty,
  input  logic [15:0]               sample_data,
  output logic                      sample_rd_en,
  input  logic                      sample_full,
  input  logic                      sample_almost_full,
  input  logic                      sample_empty,
  input  logic                      sample_almost_empty
);

  daq_pkg::bridge_state_t state;
  daq_pkg::bridge_state_t next_state;

  logic [15:0] cmd_word [5];
  logic [2:0]  word_idx;
  logic        wr_cycle;
  logic        rd_cycle;
  logic        fetch_wr;
  logic        word_wr;
  logic        time_clear;
  logic        run_wr;
  logic        run;
  logic        rd_d;
  logic        rd_dd;
  logic        rd_done;
  logic [15:0] status;
  logic [15:0] status_ref;
  logic [15:0] prefetch;
  logic        sample_valid;
  logic        fill_pending;

  // --------------------
  // bus decode
  // --------------------
  assign wr_cycle = cs & wr;
  assign rd_cycle = cs & rd;
  assign fetch_wr = wr_cycle && (state == daq_pkg::st_fetch);

  assign word_wr    = fetch_wr && (addr >= daq_pkg::addr_cmd_w1)
                      && (addr <= daq_pkg::addr_cmd_w5);
  assign word_idx   = 3'(addr - daq_pkg::addr_cmd_w1);
  assign time_clear = fetch_wr && (addr == daq_pkg::addr_reset_time);
  assign run_wr     = fetch_wr && (addr == daq_pkg::addr_run_time);

  // rd falling edge seen two cycles late
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_d  <= 1'b0;
      rd_dd <= 1'b0;
    end else begin
      rd_d  <= rd_cycle;
      rd_dd <= rd_d;
    end
  end

  assign rd_done = rd_dd & ~rd_d;

  // --------------------
  // control fsm
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= daq_pkg::st_fetch;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      daq_pkg::st_fetch: begin
        if (wr_cycle) begin
          if (addr == daq_pkg::addr_cmd_w5) begin
            next_state = daq_pkg::st_cmd_push;
          end
        end else if (rd_cycle && addr == daq_pkg::addr_next_sample && sample_valid) begin
          // only hold when a real sample goes out
          next_state = daq_pkg::st_read_hold;
        end
      end
      daq_pkg::st_cmd_push: next_state = daq_pkg::st_wait_release;
      daq_pkg::st_wait_release: begin
        if (!rd && !wr) begin
          next_state = daq_pkg::st_fetch;
        end
      end
      daq_pkg::st_read_hold: begin
        if (rd_done) begin
          next_state = daq_pkg::st_read_done;
        end
      end
      daq_pkg::st_read_done: next_state = daq_pkg::st_fetch;
      default: next_state = daq_pkg::st_fetch;
    endcase
  end

  assign cmd_wr_en = (state == daq_pkg::st_cmd_push);

  // --------------------
  // command words
  // --------------------
  always_ff @(posedge clk) begin
    if (word_wr) begin
      cmd_word[word_idx] <= data_in;
    end
  end

  assign cmd_data[daq_pkg::cmd_word1_lsb +: 16] = cmd_word[0];
  assign cmd_data[daq_pkg::cmd_count_lsb +: 16] = cmd_word[1];
  assign cmd_data[daq_pkg::cmd_start_lsb +: 16] = cmd_word[2];
  assign cmd_data[daq_pkg::cmd_step_lsb +: 16]  = cmd_word[3];
  assign cmd_data[daq_pkg::cmd_tag_lsb +: 16]   = cmd_word[4];

  // --------------------
  // status and irq
  // --------------------
  always_comb begin
    status = '0;
    status[daq_pkg::stat_cmd_afull]    = cmd_almost_full;
    status[daq_pkg::stat_cmd_full]     = cmd_full;
    status[daq_pkg::stat_cmd_aempty]   = cmd_almost_empty;
    status[daq_pkg::stat_cmd_empty]    = cmd_empty;
    status[daq_pkg::stat_smp_afull]    = sample_almost_full;
    status[daq_pkg::stat_smp_full]     = sample_full;
    status[daq_pkg::stat_smp_empty]    = sample_empty;
    status[daq_pkg::stat_smp_aempty]   = sample_almost_empty;
    status[daq_pkg::stat_sample_valid] = sample_valid;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      data_out   <= '0;
      status_ref <= daq_pkg::status_reset;
      irq        <= 1'b0;
    end else begin
      if (rd_cycle && addr == daq_pkg::addr_status) begin
        // host has seen the flags
        irq <= 1'b0;
      end else begin
        irq <= (status != status_ref);
      end
      if (rd_cycle) begin
        if (addr == daq_pkg::addr_status) begin
          data_out   <= status;
          status_ref <= status;
        end else if (addr == daq_pkg::addr_next_sample) begin
          data_out <= sample_valid ? prefetch : daq_pkg::empty_sample;
        end else begin
          data_out <= '0;
        end
      end
    end
  end

  // --------------------
  // sample prefetch
  // --------------------
  assign sample_rd_en = ~sample_valid & ~fill_pending & ~sample_empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      sample_valid <= 1'b0;
      fill_pending <= 1'b0;
    end else begin
      fill_pending <= sample_rd_en;
      if (fill_pending) begin
        sample_valid <= 1'b1;
      end else if (state == daq_pkg::st_read_hold && rd_done) begin
        sample_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill_pending) begin
      prefetch <= sample_data;
    end
  end

  // --------------------
  // run-time counter
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      global_clock <= '0;
      run          <= 1'b0;
    end else begin
      if (time_clear) begin
        global_clock <= '0;
      end else if (run) begin
        global_clock <= global_clock + 32'd1;
      end
      if (run_wr) begin
        run <= data_in[0];
      end
    end
  end

endmodule

// File: rtl/cmd_engine.sv
module cmd_engine (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [daq_pkg::cmd_w-1:0] cmd_data,
  input  logic                      cmd_empty,
  input  logic                      smp_full,
  output logic                      cmd_rd_en,
  output logic                      smp_wr_en,
  output logic [15:0]               smp_data
);

  typedef enum logic [1:0] {
    eng_idle,
    eng_load,
    eng_emit
  } eng_state_t;

  eng_state_t state;

  daq_pkg::opcode_t cmd_op;
  logic [15:0]      cmd_count;
  logic             op_known;
  logic [15:0]      remaining;
  logic [15:0]      value;
  logic [15:0]      step;
  logic             is_ramp;

  // --------------------
  // command decode
  // --------------------
  assign cmd_op    = daq_pkg::opcode_t'(cmd_data[daq_pkg::cmd_op_lsb +: 4]);
  assign cmd_count = cmd_data[daq_pkg::cmd_count_lsb +: 16];
  assign op_known  = (cmd_op == daq_pkg::op_ramp) || (cmd_op == daq_pkg::op_fill);

  // pop as soon as idle so the data shows up in load
  assign cmd_rd_en = (state == eng_idle) && !cmd_empty;

  // a full sample fifo stalls with sample and count held
  assign smp_wr_en = (state == eng_emit) && !smp_full;
  assign smp_data  = value;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= eng_idle;
      remaining <= '0;
    end else begin
      case (state)
        eng_idle: begin
          if (cmd_rd_en) begin
            state <= eng_load;
          end
        end
        eng_load: begin
          remaining <= cmd_count;
          // nop, unknown opcode or zero count just drop
          if (op_known && cmd_count != '0) begin
            state <= eng_emit;
          end else begin
            state <= eng_idle;
          end
        end
        eng_emit: begin
          if (smp_wr_en) begin
            remaining <= remaining - 16'd1;
            if (remaining == 16'd1) begin
              state <= eng_idle;
            end
          end
        end
        default: state <= eng_idle;
      endcase
    end
  end

  // sample generator
  always_ff @(posedge clk) begin
    if (state == eng_load) begin
      value   <= cmd_data[daq_pkg::cmd_start_lsb +: 16];
      step    <= cmd_data[daq_pkg::cmd_step_lsb +: 16];
      is_ramp <= (cmd_op == daq_pkg::op_ramp);
    end else if (smp_wr_en && is_ramp) begin
      // wraps at 16 bits
      value <= value + step;
    end
  end

endmodule

// File: rtl/daq_top.sv
module daq_top (
  input  logic        clk,
  input  logic        rst,
  input  logic        cs,
  input  logic        rd,
  input  logic        wr,
  input  logic [18:0] addr,
  input  logic [15:0] data_in,
  output logic [15:0] data_out,
  output logic        irq,
  output logic [31:0] global_clock
);

  // command path
  logic                      cmd_wr_en;
  logic [daq_pkg::cmd_w-1:0] cmd_wr_data;
  logic                      cmd_rd_en;
  logic [daq_pkg::cmd_w-1:0] cmd_rd_data;
  logic                      cmd_full;
  logic                      cmd_almost_full;
  logic                      cmd_empty;
  logic                      cmd_almost_empty;

  // sample path
  logic                      smp_wr_en;
  logic [15:0]               smp_wr_data;
  logic                      smp_rd_en;
  logic [15:0]               smp_rd_data;
  logic                      smp_full;
  logic                      smp_almost_full;
  logic                      smp_empty;
  logic                      smp_almost_empty;

  ebi_bridge u_bridge (
    .clk                 (clk),
    .rst                 (rst),
    .cs                  (cs),
    .rd                  (rd),
    .wr                  (wr),
    .addr                (addr),
    .data_in             (data_in),
    .data_out            (data_out),
    .irq                 (irq),
    .global_clock        (global_clock),
    .cmd_wr_en           (cmd_wr_en),
    .cmd_data            (cmd_wr_data),
    .cmd_full            (cmd_full),
    .cmd_almost_full     (cmd_almost_full),
    .cmd_empty           (cmd_empty),
    .cmd_almost_empty    (cmd_almost_empty),
    .sample_data         (smp_rd_data),
    .sample_rd_en        (smp_rd_en),
    .sample_full         (smp_full),
    .sample_almost_full  (smp_almost_full),
    .sample_empty        (smp_empty),
    .sample_almost_empty (smp_almost_empty)
  );

  sync_fifo #(
    .WIDTH (daq_pkg::cmd_w),
    .DEPTH (daq_pkg::cmd_depth)
  ) u_cmd_fifo (
    .clk          (clk),
    .rst          (rst),
    .wr_en        (cmd_wr_en),
    .wr_data      (cmd_wr_data),
    .rd_en        (cmd_rd_en),
    .rd_data      (cmd_rd_data),
    .full         (cmd_full),
    .almost_full  (cmd_almost_full),
    .empty        (cmd_empty),
    .almost_empty (cmd_almost_empty)
  );

  cmd_engine u_engine (
    .clk       (clk),
    .rst       (rst),
    .cmd_data  (cmd_rd_data),
    .cmd_empty (cmd_empty),
    .smp_full  (smp_full),
    .cmd_rd_en (cmd_rd_en),
    .smp_wr_en (smp_wr_en),
    .smp_data  (smp_wr_data)
  );

  sync_fifo #(
    .WIDTH (16),
    .DEPTH (daq_pkg::sample_depth)
  ) u_smp_fifo (
    .clk          (clk),
    .rst          (rst),
    .wr_en        (smp_wr_en),
    .wr_data      (smp_wr_data),
    .rd_en        (smp_rd_en),
    .rd_data      (smp_rd_data),
    .full         (smp_full),
    .almost_full  (smp_almost_full),
    .empty        (smp_empty),
    .almost_empty (smp_almost_empty)
  );

endmodule

// File: sim/clk_gen.sv
module clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // reset held for the first 16 rising edges
  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// File: sim/daq_asserts.sv
module daq_asserts (
  input logic clk,
  input logic rst,
  input logic cmd_wr_en,
  input logic sample_rd_en,
  input logic sample_valid,
  input logic irq
);

  int fail_count = 0;

  // one push per completed command
  cmd_push_single: assert property (@(posedge clk) disable iff (rst)
    cmd_wr_en |=> !cmd_wr_en)
    else begin
      $error("cmd_wr_en stayed high for two cycles");
      fail_count++;
    end

  // refill only into an empty prefetch register
  refill_when_empty: assert property (@(posedge clk) disable iff (rst)
    sample_rd_en |-> !sample_valid)
    else begin
      $error("sample_rd_en fired while the prefetch register was valid");
      fail_count++;
    end

  irq_low_after_reset: assert property (@(posedge clk) $fell(rst) |-> !irq)
    else begin
      $error("irq high in the cycle after reset");
      fail_count++;
    end

endmodule

// File: sim/daq_checker.sv
module daq_checker (
  input logic        clk,
  input logic        rst,
  input logic        cs,
  input logic        rd,
  input logic        wr,
  input logic [18:0] addr,
  input logic [15:0] data_in,
  input logic [15:0] data_out,
  input logic        irq,
  input logic [31:0] global_clock
);

  logic [15:0] words [5];
  logic [15:0] expected [$];
  logic        wr_prev = 1'b0;
  logic        rd_prev = 1'b0;
  logic [18:0] rd_addr = '0;
  logic [15:0] stat_mask = '0;
  logic [15:0] stat_value = '0;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          tests_failed = 0;
  int          test_start_errors = 0;
  string       test_name = "";

  // --------------------
  // compare helpers
  // --------------------
  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("test %0d %s: %s", tests, test_name, what);
  endtask

  task automatic expect_status(input logic [15:0] mask, input logic [15:0] value);
    stat_mask  = mask;
    stat_value = value;
  endtask

  task automatic check_irq(input logic exp);
    compare("irq", 32'(irq), 32'(exp));
  endtask

  task automatic check_clock(input logic [31:0] exp);
    compare("global_clock", global_clock, exp);
  endtask

  task automatic check_queue_empty();
    checks++;
    if (expected.size() != 0) begin
      errors++;
      $display("%0d expected samples were never read back", expected.size());
    end
  endtask

  // --------------------
  // sample model
  // --------------------
  task automatic add_command();
    logic [daq_pkg::cmd_w-1:0] cmd;
    logic [3:0]                op;
    logic [15:0]               count;
    logic [15:0]               value;
    logic [15:0]               step;
    cmd   = {words[0], words[1], words[2], words[3], words[4]};
    op    = cmd[daq_pkg::cmd_op_lsb +: 4];
    count = cmd[daq_pkg::cmd_count_lsb +: 16];
    value = cmd[daq_pkg::cmd_start_lsb +: 16];
    step  = cmd[daq_pkg::cmd_step_lsb +: 16];
    if (op == daq_pkg::op_ramp || op == daq_pkg::op_fill) begin
      for (int i = 0; i < int'(count); i++) begin
        expected.push_back(value);
        if (op == daq_pkg::op_ramp) begin
          value = value + step;
        end
      end
    end
  endtask

  task automatic check_read();
    logic [15:0] exp;
    if (rd_addr == daq_pkg::addr_status && stat_mask != '0) begin
      compare("data_out (status)", 32'(data_out & stat_mask), 32'(stat_value));
      stat_mask = '0;
    end else if (rd_addr == daq_pkg::addr_next_sample) begin
      if (expected.size() > 0) begin
        exp = expected.pop_front();
      end else begin
        exp = daq_pkg::empty_sample;
      end
      compare("data_out (sample)", 32'(data_out), 32'(exp));
    end
  endtask

  // bus monitor takes a read result once rd has dropped
  always @(posedge clk) begin
    if (rst) begin
      wr_prev = 1'b0;
      rd_prev = 1'b0;
    end else begin
      if (cs && wr && addr >= daq_pkg::addr_cmd_w1 && addr <= daq_pkg::addr_cmd_w5) begin
        words[int'(addr - daq_pkg::addr_cmd_w1)] = data_in;
      end
      if (cs && wr && !wr_prev && addr == daq_pkg::addr_cmd_w5) begin
        add_command();
      end
      if (rd_prev && !(cs && rd)) begin
        check_read();
      end
      if (cs && rd) begin
        rd_addr = addr;
      end
      wr_prev = cs & wr;
      rd_prev = cs & rd;
    end
  end

  // --------------------
  // reporting
  // --------------------
  task automatic start_test(input string name);
    tests++;
    test_name = name;
    test_start_errors = errors;
  endtask

  task automatic end_test();
    if (errors == test_start_errors) begin
      $display("test %0d %s: pass", tests, test_name);
    end else begin
      tests_failed++;
      $display("test %0d %s: fail, %0d errors", tests, test_name, errors - test_start_errors);
    end
  endtask

  task automatic report_counts(input int assert_errors);
    $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             tests, tests_failed, checks, errors, assert_errors);
  endtask

endmodule

// File: sim/tb_daq.sv
module tb_daq;

  logic        clk;
  logic        rst;
  logic        cs;
  logic        rd;
  logic        wr;
  logic [18:0] addr;
  logic [15:0] data_in;
  logic [15:0] data_out;
  logic        irq;
  logic [31:0] global_clock;

  logic [31:0] rng;
  logic [15:0] status;
  logic [15:0] smp;
  logic [3:0]  op;
  logic [31:0] t0;
  int          n;
  int          total_errors;

  clk_gen u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  daq_top dut (
    .clk          (clk),
    .rst          (rst),
    .cs           (cs),
    .rd           (rd),
    .wr           (wr),
    .addr         (addr),
    .data_in      (data_in),
    .data_out     (data_out),
    .irq          (irq),
    .global_clock (global_clock)
  );

  daq_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .cs           (cs),
    .rd           (rd),
    .wr           (wr),
    .addr         (addr),
    .data_in      (data_in),
    .data_out     (data_out),
    .irq          (irq),
    .global_clock (global_clock)
  );

  bind ebi_bridge daq_asserts u_asserts (
    .clk          (clk),
    .rst          (rst),
    .cmd_wr_en    (cmd_wr_en),
    .sample_rd_en (sample_rd_en),
    .sample_valid (sample_valid),
    .irq          (irq)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [15:0] bit_mask(input int pos);
    return 16'd1 << pos;
  endfunction

  // --------------------
  // bus cycles
  // --------------------
  task automatic bus_write(input logic [18:0] a, input logic [15:0] d);
    @(posedge clk);
    cs      <= 1'b1;
    wr      <= 1'b1;
    addr    <= a;
    data_in <= d;
    repeat (2) @(posedge clk);
    cs <= 1'b0;
    wr <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic bus_read(input logic [18:0] a, output logic [15:0] d);
    @(posedge clk);
    cs   <= 1'b1;
    rd   <= 1'b1;
    addr <= a;
    repeat (2) @(posedge clk);
    cs <= 1'b0;
    rd <= 1'b0;
    // data_out holds the last read cycle here
    @(posedge clk);
    d = data_out;
    @(posedge clk);
  endtask

  task automatic wait_status(input int pos, input logic level, input string what);
    int          waited;
    logic [15:0] st;
    logic        done;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < 2000) begin
      bus_read(daq_pkg::addr_status, st);
      waited += 5;
      done = (st[pos] == level);
    end
    if (!done) begin
      u_checker.report_failure($sformatf("timeout waiting for %s", what));
    end
  endtask

  task automatic wait_irq();
    int cycles;
    cycles = 0;
    while (!irq && cycles < 2000) begin
      @(posedge clk);
      cycles++;
    end
    if (!irq) begin
      u_checker.report_failure("timeout waiting for irq to rise");
    end
  endtask

  task automatic wait_reset();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (rst && cycles < 100) begin
      @(posedge clk);
      cycles++;
    end
    if (rst) begin
      u_checker.report_failure("reset was never released");
    end
  endtask

  task automatic send_cmd(input logic [3:0] opc, input logic [11:0] rsvd,
                          input logic [15:0] count, input logic [15:0] start,
                          input logic [15:0] step, input logic [15:0] tag);
    wait_status(daq_pkg::stat_cmd_full, 1'b0, "command fifo not full");
    bus_write(daq_pkg::addr_cmd_w1, {opc, rsvd});
    bus_write(daq_pkg::addr_cmd_w2, count);
    bus_write(daq_pkg::addr_cmd_w3, start);
    bus_write(daq_pkg::addr_cmd_w4, step);
    bus_write(daq_pkg::addr_cmd_w5, tag);
  endtask

  task automatic read_sample();
    wait_status(daq_pkg::stat_sample_valid, 1'b1, "sample_valid");
    bus_read(daq_pkg::addr_next_sample, smp);
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial begin
    cs      = 1'b0;
    rd      = 1'b0;
    wr      = 1'b0;
    addr    = '0;
    data_in = '0;
    rng     = 32'h1e32;
    wait_reset();

    u_checker.start_test("reset state");
    u_checker.expect_status(bit_mask(daq_pkg::stat_cmd_empty)
                            | bit_mask(daq_pkg::stat_cmd_aempty)
                            | bit_mask(daq_pkg::stat_smp_empty)
                            | bit_mask(daq_pkg::stat_sample_valid),
                            bit_mask(daq_pkg::stat_cmd_empty)
                            | bit_mask(daq_pkg::stat_smp_empty));
    bus_read(daq_pkg::addr_status, status);
    bus_read(daq_pkg::addr_next_sample, smp);
    u_checker.end_test();

    u_checker.start_test("random commands");
    for (int i = 0; i < 20; i++) begin
      rng = xorshift32(rng);
      op  = rng[0] ? daq_pkg::op_ramp : daq_pkg::op_fill;
      n   = 1 + int'(rng[10:8]) % 6;
      t0  = rng;
      rng = xorshift32(rng);
      send_cmd(op, t0[23:12], 16'(n), t0[31:16], rng[15:0], rng[31:16]);
      repeat (n) read_sample();
    end
    // no sample beyond the commanded counts
    bus_read(daq_pkg::addr_next_sample, smp);
    u_checker.check_queue_empty();
    u_checker.end_test();

    u_checker.start_test("sample back-pressure");
    for (int i = 0; i < 3; i++) begin
      rng = xorshift32(rng);
      send_cmd(daq_pkg::op_fill, 12'h000, 16'd7, rng[15:0], 16'h0000, rng[31:16]);
    end
    wait_status(daq_pkg::stat_smp_full, 1'b1, "sample fifo full");
    // engine stalled on the third command with the prefetch register loaded
    u_checker.expect_status(bit_mask(daq_pkg::stat_smp_full)
                            | bit_mask(daq_pkg::stat_smp_afull)
                            | bit_mask(daq_pkg::stat_smp_empty)
                            | bit_mask(daq_pkg::stat_sample_valid)
                            | bit_mask(daq_pkg::stat_cmd_empty),
                            bit_mask(daq_pkg::stat_smp_full)
                            | bit_mask(daq_pkg::stat_sample_valid)
                            | bit_mask(daq_pkg::stat_cmd_empty));
    bus_read(daq_pkg::addr_status, status);
    repeat (21) read_sample();
    // nothing may be left over or repeated
    bus_read(daq_pkg::addr_next_sample, smp);
    u_checker.expect_status(bit_mask(daq_pkg::stat_smp_empty)
                            | bit_mask(daq_pkg::stat_sample_valid),
                            bit_mask(daq_pkg::stat_smp_empty));
    bus_read(daq_pkg::addr_status, status);
    u_checker.check_queue_empty();
    u_checker.end_test();

    u_checker.start_test("dropped commands");
    send_cmd(daq_pkg::op_nop, 12'h000, 16'd3, 16'h1111, 16'h0001, 16'h0000);
    send_cmd(daq_pkg::op_ramp, 12'h000, 16'd0, 16'h2222, 16'h0001, 16'h0001);
    send_cmd(4'h7, 12'h000, 16'd4, 16'h3333, 16'h0001, 16'h0002);
    send_cmd(4'hf, 12'hfff, 16'd2, 16'h4444, 16'h0001, 16'h0003);
    wait_status(daq_pkg::stat_cmd_empty, 1'b1, "command fifo to drain");
    u_checker.expect_status(bit_mask(daq_pkg::stat_smp_empty)
                            | bit_mask(daq_pkg::stat_sample_valid)
                            | bit_mask(daq_pkg::stat_cmd_empty),
                            bit_mask(daq_pkg::stat_smp_empty)
                            | bit_mask(daq_pkg::stat_cmd_empty));
    bus_read(daq_pkg::addr_status, status);
    u_checker.check_queue_empty();
    u_checker.end_test();

    u_checker.start_test("run-time counter");
    bus_write(daq_pkg::addr_run_time, 16'h0001);
    rng = xorshift32(rng);
    n   = 20 + int'(rng[5:0]);
    @(posedge clk);
    t0 = global_clock;
    repeat (n) @(posedge clk);
    u_checker.check_clock(t0 + 32'(n));
    bus_write(daq_pkg::addr_run_time, 16'h0000);
    @(posedge clk);
    t0 = global_clock;
    repeat (n) @(posedge clk);
    u_checker.check_clock(t0);
    bus_write(daq_pkg::addr_reset_time, 16'h0000);
    @(posedge clk);
    u_checker.check_clock(32'd0);
    u_checker.end_test();

    u_checker.start_test("irq");
    bus_read(daq_pkg::addr_status, status);
    repeat (3) @(posedge clk);
    u_checker.check_irq(1'b0);
    rng = xorshift32(rng);
    send_cmd(daq_pkg::op_fill, 12'h000, 16'd1, rng[15:0], 16'h0000, rng[31:16]);
    wait_irq();
    // status read clears irq once the sample sits in prefetch
    wait_status(daq_pkg::stat_sample_valid, 1'b1, "sample_valid");
    @(posedge clk);
    u_checker.check_irq(1'b0);
    bus_read(daq_pkg::addr_next_sample, smp);
    wait_irq();
    bus_read(daq_pkg::addr_status, status);
    @(posedge clk);
    u_checker.check_irq(1'b0);
    u_checker.check_queue_empty();
    u_checker.end_test();

    total_errors = u_checker.errors + dut.u_bridge.u_asserts.fail_count;
    u_checker.report_counts(dut.u_bridge.u_asserts.fail_count);
    if (total_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: compile.f
rtl/daq_pkg.sv
rtl/sync_fifo.sv
rtl/ebi_bridge.sv
rtl/cmd_engine.sv
rtl/daq_top.sv
sim/clk_gen.sv
sim/daq_asserts.sv
sim/daq_checker.sv
sim/tb_daq.sv

// File: run_sim.sh
#!/bin/sh
# verilator build and run of tb_daq, result taken from the simulation log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log &&
verilator --binary --timing --assert --top-module tb_daq -f compile.f > build.log 2>&1 ||
  { cat build.log; echo "build failed"; exit 1; }

{ ./obj_dir/Vtb_daq > sim.log 2>&1 || echo "simulator returned an error status"; } &&
cat sim.log &&
grep -qF "*** PASSED ***" sim.log &&
echo "result: pass" ||
  { echo "result: fail"; exit 1; }
